// ==== all.f ====
+incdir+.
ec_pkg.sv
ring_counter.sv
timing_chain.sv
keyboard.sv
entry_sequencer.sv
delay_line.sv
slot_decoder.sv
calc_top.sv
tb_calc.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_calc
FILELIST  := all.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) ec_settings.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_calc.sv ====
// directed testbench for the calculator entry path
// register model, key press and readout scan tasks, watchdog
`include "ec_settings.svh"

module tb_calc;
    import ec_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int CIRC_CYCLES = `EC_DL_LENGTH * `EC_CLK_PER_BIT;
    localparam int SLOT_CYCLES = `EC_BITS_PER_SLOT * `EC_CLK_PER_BIT;
    localparam int NUM_SLOTS   = `EC_NUM_REGS * `EC_NUM_COLS;
    // key presses and scans over all tests
    localparam int NUM_PRESSES = 12 + 20 + 5 + 2;
    localparam int NUM_SCANS   = 1 + 12 + 1 + 5 + 2;
    // a press takes at most about two circulations so three leave margin
    localparam longint WATCHDOG_TIME =
        longint'((NUM_PRESSES * 3 + NUM_SCANS + 4) * CIRC_CYCLES + 10) * CLK_PERIOD;

    logic       clk;
    logic       i_arst_n;
    logic [9:0] key_digit;
    logic       key_clr_ent;
    logic       key_enter;
    logic       kbd_ack;
    logic       kbd_lock;
    logic       rd_valid;
    slot_rd_t   rd;

    // expected and last scanned digits
    // register 0 is entry and register 1 is stack
    int model [`EC_NUM_REGS][`EC_NUM_COLS];
    int got   [`EC_NUM_REGS][`EC_NUM_COLS];

    calc_top uut (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_key_digit   (key_digit),
        .i_key_clr_ent (key_clr_ent),
        .i_key_enter   (key_enter),
        .o_kbd_ack     (kbd_ack),
        .o_kbd_lock    (kbd_lock),
        .o_rd_valid    (rd_valid),
        .o_rd          (rd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string test_name, input int expected, input int actual);
        if (expected !== actual) begin
            fail_run($sformatf("Mismatch in %s: expected %0d, actual %0d",
                               test_name, expected, actual));
        end
    endtask

    // new digit lands in column 0 and column 15 is lost
    task automatic model_digit(input int d);
        for (int c = `EC_NUM_COLS - 1; c > 0; c--) begin
            model[0][c] = model[0][c - 1];
        end
        model[0][0] = d;
    endtask

    task automatic model_enter();
        for (int c = 0; c < `EC_NUM_COLS; c++) begin
            model[1][c] = model[0][c];
        end
    endtask

    task automatic model_clear();
        for (int c = 0; c < `EC_NUM_COLS; c++) begin
            model[0][c] = 0;
        end
    endtask

    task automatic release_keys();
        key_digit   = '0;
        key_clr_ent = 1'b0;
        key_enter   = 1'b0;
    endtask

    // hold a key until acked and wait for the lock to drop
    // optionally keep it held past the lock or press clear-entry while locked
    task automatic press_key(input string name, input logic [9:0] digits, input logic clr,
                             input logic ent, input bit hold_through, input bit stray_clear);
        int cycles;
        int acks;
        key_digit   = digits;
        key_clr_ent = clr;
        key_enter   = ent;
        cycles      = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!kbd_ack && cycles <= 2 * `EC_KEYBOARD_DELAY);
        if (!kbd_ack) begin
            fail_run($sformatf("%s: held key was never acknowledged", name));
        end
        // the first negedge already follows the first posedge that saw the key
        check_value($sformatf("%s ack delay", name), `EC_KEYBOARD_DELAY, cycles - 1);
        acks = 1;
        @(negedge clk);
        check_value($sformatf("%s ack width", name), 0, int'(kbd_ack));
        check_value($sformatf("%s lock after ack", name), 1, int'(kbd_lock));
        if (!hold_through) begin
            release_keys();
        end
        if (stray_clear) begin
            @(negedge clk);
            key_clr_ent = 1'b1;
            repeat (4 * `EC_KEYBOARD_DELAY) begin
                @(negedge clk);
                if (kbd_ack) begin
                    acks++;
                end
            end
            check_value($sformatf("%s lock during stray key", name), 1, int'(kbd_lock));
            key_clr_ent = 1'b0;
        end
        cycles = 0;
        while (kbd_lock && cycles < 3 * CIRC_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (kbd_ack) begin
                acks++;
            end
        end
        if (kbd_lock) begin
            fail_run($sformatf("%s: keyboard lock never dropped", name));
        end
        if (hold_through) begin
            repeat (2 * `EC_KEYBOARD_DELAY) begin
                @(negedge clk);
                if (kbd_ack) begin
                    acks++;
                end
            end
            release_keys();
        end
        check_value($sformatf("%s ack count", name), 1, acks);
    endtask

    // 32 back to back strobes must name every slot once
    task automatic scan_registers(input string name);
        bit seen [`EC_NUM_REGS][`EC_NUM_COLS];
        int wait_cycles;
        int r;
        int c;
        for (int i = 0; i < `EC_NUM_REGS; i++) begin
            for (int j = 0; j < `EC_NUM_COLS; j++) begin
                seen[i][j] = 1'b0;
            end
        end
        for (int n = 0; n < NUM_SLOTS; n++) begin
            wait_cycles = 0;
            do begin
                @(negedge clk);
                wait_cycles++;
            end while (!rd_valid && wait_cycles < 2 * SLOT_CYCLES);
            if (!rd_valid) begin
                fail_run($sformatf("%s: no readout strobe within two slot times", name));
            end
            r = int'(rd.reg_no);
            c = int'(rd.col);
            if (seen[r][c]) begin
                fail_run($sformatf("%s: register %0d column %0d read twice in one circulation",
                                   name, r, c));
            end
            seen[r][c] = 1'b1;
            got[r][c]  = int'(rd.digit);
            check_value($sformatf("%s reg %0d col %0d", name, r, c), model[r][c], got[r][c]);
        end
    endtask

    task automatic test_random_digits();
        int d;
        for (int k = 0; k < 12; k++) begin
            d = int'($urandom % 10);
            press_key($sformatf("random digit %0d", k), 10'd1 << d, 1'b0, 1'b0, 1'b0, 1'b0);
            model_digit(d);
            scan_registers($sformatf("random digit %0d", k));
        end
    endtask

    task automatic test_twenty_digits();
        int keys [20];
        for (int k = 0; k < 20; k++) begin
            keys[k] = int'($urandom % 10);
            press_key($sformatf("twenty digits key %0d", k), 10'd1 << keys[k],
                      1'b0, 1'b0, 1'b0, 1'b0);
            model_digit(keys[k]);
        end
        scan_registers("twenty digits");
        // newest key in column 0 and the four oldest gone
        for (int c = 0; c < `EC_NUM_COLS; c++) begin
            check_value($sformatf("twenty digits order col %0d", c), keys[19 - c], got[0][c]);
        end
    endtask

    task automatic test_enter_clear();
        int d;
        press_key("enter", 10'd0, 1'b0, 1'b1, 1'b0, 1'b0);
        model_enter();
        scan_registers("enter");
        for (int k = 0; k < 3; k++) begin
            d = int'($urandom % 10);
            press_key($sformatf("digit after enter %0d", k), 10'd1 << d,
                      1'b0, 1'b0, 1'b0, 1'b0);
            model_digit(d);
            scan_registers($sformatf("digit after enter %0d", k));
        end
        press_key("clear entry", 10'd0, 1'b1, 1'b0, 1'b0, 1'b0);
        model_clear();
        scan_registers("clear entry");
    endtask

    task automatic test_held_keys();
        press_key("held key", 10'd1 << 5, 1'b0, 1'b0, 1'b1, 1'b0);
        model_digit(5);
        scan_registers("held key");
        // the clear-entry held under the lock must leave no trace
        press_key("key during lock", 10'd1 << 8, 1'b0, 1'b0, 1'b0, 1'b1);
        model_digit(8);
        scan_registers("key during lock");
    endtask

    initial begin
        clk         = 1'b0;
        i_arst_n    = 1'b0;
        key_digit   = '0;
        key_clr_ent = 1'b0;
        key_enter   = 1'b0;
        void'($urandom(89));
        for (int i = 0; i < `EC_NUM_REGS; i++) begin
            for (int j = 0; j < `EC_NUM_COLS; j++) begin
                model[i][j] = 0;
                got[i][j]   = 0;
            end
        end
        repeat (5) @(negedge clk);
        i_arst_n = 1'b1;
        scan_registers("reset readout");
        test_random_digits();
        test_twenty_digits();
        test_enter_clear();
        test_held_keys();
        $display("Test OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        fail_run("the run timed out before all tests finished");
    end

endmodule

// ==== calc_top.sv ====
// calculator entry top level
// timing chain, keyboard, sequencer, delay line and slot readout

module calc_top (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic [9:0]       i_key_digit,
    input  logic             i_key_clr_ent,
    input  logic             i_key_enter,
    output logic             o_kbd_ack,
    output logic             o_kbd_lock,
    output logic             o_rd_valid,
    output ec_pkg::slot_rd_t o_rd
);
    import ec_pkg::*;

    logic     bit_tick;
    dl_pos_t  pos;
    logic     home;
    logic     cmd_stb;
    key_cmd_t cmd;
    logic     wr_en;
    logic     wr_bit;
    logic     rd_bit;

    assign o_kbd_ack = cmd_stb;

    timing_chain u_timing (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .o_bit_tick (bit_tick),
        .o_pos      (pos),
        .o_home     (home)
    );

    keyboard u_keyboard (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_key_digit   (i_key_digit),
        .i_key_clr_ent (i_key_clr_ent),
        .i_key_enter   (i_key_enter),
        .i_kbd_lock    (o_kbd_lock),
        .o_cmd_stb     (cmd_stb),
        .o_cmd         (cmd)
    );

    entry_sequencer u_sequencer (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_bit_tick (bit_tick),
        .i_pos      (pos),
        .i_home     (home),
        .i_cmd_stb  (cmd_stb),
        .i_cmd      (cmd),
        .i_rd_bit   (rd_bit),
        .o_wr_en    (wr_en),
        .o_wr_bit   (wr_bit),
        .o_kbd_lock (o_kbd_lock)
    );

    delay_line u_delay_line (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_bit_tick (bit_tick),
        .i_wr_en    (wr_en),
        .i_wr_bit   (wr_bit),
        .o_rd_bit   (rd_bit)
    );

    slot_decoder u_slot_decoder (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_bit_tick (bit_tick),
        .i_pos      (pos),
        .i_rd_bit   (rd_bit),
        .o_rd_valid (o_rd_valid),
        .o_rd       (o_rd)
    );

endmodule

// ==== slot_decoder.sv ====
// slot decoder: counts pulses per slot on a ring counter
// and strobes out the digit with its register and column
`include "ec_settings.svh"

module slot_decoder (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_bit_tick,
    input  ec_pkg::dl_pos_t  i_pos,
    input  logic             i_rd_bit,
    output logic             o_rd_valid,
    output ec_pkg::slot_rd_t o_rd
);
    import ec_pkg::*;

    logic slot_end;
    bcd_t count_bcd;

    assign slot_end = i_bit_tick && (i_pos.bit_no == bit_idx_t'(`EC_BITS_PER_SLOT - 1));

    // clear wins over the step on the last bit of the slot
    ring_counter count_ring (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_clear     (slot_end),
        .i_load      (1'b0),
        .i_load_code ('0),
        .i_up        (i_bit_tick && i_rd_bit),
        .i_down      (1'b0),
        .o_code      (),
        .o_zero      (),
        .o_bcd       (count_bcd)
    );

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= slot_end;
        end
    end

    always_ff @(posedge clk) begin
        if (slot_end) begin
            o_rd.reg_no <= i_pos.reg_no;
            o_rd.col    <= i_pos.col;
            o_rd.digit  <= count_bcd;
        end
    end

endmodule

// ==== delay_line.sv ====
// recirculating delay-line memory with tail write override
`include "ec_settings.svh"

module delay_line (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_bit_tick,
    input  logic i_wr_en,
    input  logic i_wr_bit,
    output logic o_rd_bit
);

    localparam int LEN = `EC_DL_LENGTH;

    logic [LEN-1:0] line_q;
    logic           tail_bit;

    // head bit comes out of the top end
    assign o_rd_bit = line_q[LEN-1];

    // recirculate unless the sequencer overrides
    assign tail_bit = i_wr_en ? i_wr_bit : line_q[LEN-1];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            line_q <= '0;
        end else if (i_bit_tick) begin
            line_q <= {line_q[LEN-2:0], tail_bit};
        end
    end

endmodule

// ==== entry_sequencer.sv ====
// entry sequencer: operation FSM with carry and emit ring counters
// rewriting entry and stack slots over one circulation

module entry_sequencer (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_bit_tick,
    input  ec_pkg::dl_pos_t  i_pos,
    input  logic             i_home,
    input  logic             i_cmd_stb,
    input  ec_pkg::key_cmd_t i_cmd,
    input  logic             i_rd_bit,
    output logic             o_wr_en,
    output logic             o_wr_bit,
    output logic             o_kbd_lock
);
    import ec_pkg::*;

    seq_state_t state;
    key_op_t    op_q;
    logic       accept;
    logic       run;
    logic       run_tick;
    logic       in_entry;
    logic       slot_end;
    logic       emit_slot;
    logic       emit_zero;
    logic       carry_clear;
    logic       emit_load;
    ring_code_t carry_code;
    ring_code_t emit_load_code;

    assign accept   = (state == S_IDLE) && i_cmd_stb;
    assign run      = (state == S_RUN);
    assign run_tick = run && i_bit_tick;
    assign in_entry = (i_pos.reg_no == '0);
    assign slot_end = (i_pos.bit_no == '1);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= S_IDLE;
            op_q  <= OP_DIGIT;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_cmd_stb) begin
                        state <= S_WAIT_HOME;
                        op_q  <= i_cmd.op;
                    end
                end
                S_WAIT_HOME: begin
                    if (i_home) begin
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    // the home tick is the last bit of this circulation
                    if (i_home) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign o_kbd_lock = (state != S_IDLE);

    // digit writes the entry slots, enter writes the stack slots
    assign emit_slot = run && ((op_q == OP_DIGIT && in_entry) ||
                               (op_q == OP_ENTER && !in_entry));

    assign o_wr_bit = emit_slot && !emit_zero;
    assign o_wr_en  = emit_slot || (run && op_q == OP_CLEAR_ENTRY && in_entry);

    // entry slot digit moves into emit at slot end, one column up
    assign carry_clear    = accept || (run_tick && in_entry && slot_end);
    assign emit_load      = accept || (run_tick && in_entry && slot_end);
    assign emit_load_code = accept ? i_cmd.digit : carry_code;

    ring_counter carry_ring (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_clear     (carry_clear),
        .i_load      (1'b0),
        .i_load_code ('0),
        .i_up        (run_tick && in_entry && i_rd_bit),
        .i_down      (1'b0),
        .o_code      (carry_code),
        .o_zero      (),
        .o_bcd       ()
    );

    ring_counter emit_ring (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_clear     (1'b0),
        .i_load      (emit_load),
        .i_load_code (emit_load_code),
        .i_up        (1'b0),
        .i_down      (run_tick && emit_slot && !emit_zero),
        .o_code      (),
        .o_zero      (emit_zero),
        .o_bcd       ()
    );

endmodule

// ==== keyboard.sv ====
// keyboard: debounce counter, one-shot acknowledge under lock,
// key priority and command encoding
`include "ec_settings.svh"

module keyboard (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic [9:0]       i_key_digit,
    input  logic             i_key_clr_ent,
    input  logic             i_key_enter,
    input  logic             i_kbd_lock,
    output logic             o_cmd_stb,
    output ec_pkg::key_cmd_t o_cmd
);
    import ec_pkg::*;

    localparam int CNT_W = $clog2(`EC_KEYBOARD_DELAY + 2);
    localparam logic [CNT_W-1:0] CNT_FIRE = CNT_W'(`EC_KEYBOARD_DELAY);
    localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(`EC_KEYBOARD_DELAY + 1);

    logic             any_key;
    logic [CNT_W-1:0] deb_cnt;
    key_cmd_t         cmd_next;

    assign any_key = (|i_key_digit) | i_key_clr_ent | i_key_enter;

    // clear-entry wins, then enter, then the lowest digit held
    always_comb begin
        bcd_t low_digit;
        low_digit = '0;
        for (int i = 9; i >= 0; i--) begin
            if (i_key_digit[i]) begin
                low_digit = bcd_t'(i);
            end
        end
        if (i_key_clr_ent) begin
            cmd_next.op = OP_CLEAR_ENTRY;
        end else if (i_key_enter) begin
            cmd_next.op = OP_ENTER;
        end else begin
            cmd_next.op = OP_DIGIT;
        end
        cmd_next.digit = bcd_to_ring(low_digit);
    end

    // count freezes under the lock and saturates after firing,
    // so a held key is taken once; release restarts it
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            deb_cnt   <= '0;
            o_cmd_stb <= 1'b0;
        end else begin
            o_cmd_stb <= 1'b0;
            if (!any_key) begin
                deb_cnt <= '0;
            end else if (!i_kbd_lock && deb_cnt != CNT_DONE) begin
                deb_cnt   <= deb_cnt + 1'b1;
                o_cmd_stb <= (deb_cnt == CNT_FIRE);
            end
        end
    end

    always_ff @(posedge clk) begin
        o_cmd <= cmd_next;
    end

endmodule

// ==== timing_chain.sv ====
// timing chain: bit strobe divider, bit/register/column counters
// and the circulation home strobe
`include "ec_settings.svh"

module timing_chain (
    input  logic            clk,
    input  logic            i_arst_n,
    output logic            o_bit_tick,
    output ec_pkg::dl_pos_t o_pos,
    output logic            o_home
);
    import ec_pkg::*;

    localparam int DIV_W = $clog2(`EC_CLK_PER_BIT);

    logic [DIV_W-1:0] div_cnt;
    logic             bit_last;
    logic             reg_last;
    logic             col_last;

    // divide the master clock down to one strobe per bit time
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            div_cnt <= '0;
        end else if (o_bit_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign o_bit_tick = (div_cnt == DIV_W'(`EC_CLK_PER_BIT - 1));

    assign bit_last = (o_pos.bit_no == bit_idx_t'(`EC_BITS_PER_SLOT - 1));
    assign reg_last = (o_pos.reg_no == reg_idx_t'(`EC_NUM_REGS - 1));
    assign col_last = (o_pos.col == col_idx_t'(`EC_NUM_COLS - 1));

    // bit counter carries into register, register into column
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pos <= '0;
        end else if (o_bit_tick) begin
            o_pos.bit_no <= bit_last ? '0 : o_pos.bit_no + 1'b1;
            if (bit_last) begin
                o_pos.reg_no <= reg_last ? '0 : o_pos.reg_no + 1'b1;
                if (reg_last) begin
                    o_pos.col <= col_last ? '0 : o_pos.col + 1'b1;
                end
            end
        end
    end

    // last bit of the circulation, position wraps to zero here
    assign o_home = o_bit_tick & bit_last & reg_last & col_last;

endmodule

// ==== ring_counter.sv ====
// five-stage johnson counter with clear, load, up/down step
// and BCD decode

module ring_counter (
    input  logic               clk,
    input  logic               i_arst_n,
    input  logic               i_clear,
    input  logic               i_load,
    input  ec_pkg::ring_code_t i_load_code,
    input  logic               i_up,
    input  logic               i_down,
    output ec_pkg::ring_code_t o_code,
    output logic               o_zero,
    output ec_pkg::bcd_t       o_bcd
);
    import ec_pkg::*;

    ring_code_t code_q;

    // up shifts left feeding back the inverted top stage,
    // down shifts right feeding back the inverted bottom stage
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            code_q <= '0;
        end else if (i_clear) begin
            code_q <= '0;
        end else if (i_load) begin
            code_q <= i_load_code;
        end else if (i_up) begin
            code_q <= {code_q[3:0], ~code_q[4]};
        end else if (i_down) begin
            code_q <= {~code_q[0], code_q[4:1]};
        end
    end

    assign o_code = code_q;
    assign o_zero = (code_q == '0);
    assign o_bcd  = ring_to_bcd(code_q);

endmodule

// ==== ec_pkg.sv ====
// shared types for the calculator entry path
// ring code to BCD conversions
`include "ec_settings.svh"

package ec_pkg;

    typedef logic [$clog2(`EC_BITS_PER_SLOT)-1:0] bit_idx_t;
    typedef logic [$clog2(`EC_NUM_REGS)-1:0]      reg_idx_t;
    typedef logic [$clog2(`EC_NUM_COLS)-1:0]      col_idx_t;
    typedef logic [3:0]                           bcd_t;
    typedef logic [4:0]                           ring_code_t;

    // register sits below column so both registers of a column are adjacent
    typedef struct packed {
        col_idx_t col;
        reg_idx_t reg_no;
        bit_idx_t bit_no;
    } dl_pos_t;

    typedef enum logic [1:0] {
        OP_DIGIT,
        OP_CLEAR_ENTRY,
        OP_ENTER
    } key_op_t;

    typedef struct packed {
        key_op_t    op;
        ring_code_t digit;
    } key_cmd_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_HOME,
        S_RUN
    } seq_state_t;

    typedef struct packed {
        reg_idx_t reg_no;
        col_idx_t col;
        bcd_t     digit;
    } slot_rd_t;

    // johnson code to digit, 15 flags a code outside the ten states
    function automatic bcd_t ring_to_bcd(ring_code_t code);
        case (code)
            5'b00000: return 4'd0;
            5'b00001: return 4'd1;
            5'b00011: return 4'd2;
            5'b00111: return 4'd3;
            5'b01111: return 4'd4;
            5'b11111: return 4'd5;
            5'b11110: return 4'd6;
            5'b11100: return 4'd7;
            5'b11000: return 4'd8;
            5'b10000: return 4'd9;
            default:  return 4'd15;
        endcase
    endfunction

    function automatic ring_code_t bcd_to_ring(bcd_t digit);
        case (digit)
            4'd1:    return 5'b00001;
            4'd2:    return 5'b00011;
            4'd3:    return 5'b00111;
            4'd4:    return 5'b01111;
            4'd5:    return 5'b11111;
            4'd6:    return 5'b11110;
            4'd7:    return 5'b11100;
            4'd8:    return 5'b11000;
            4'd9:    return 5'b10000;
            default: return 5'b00000;
        endcase
    endfunction

endpackage

// ==== ec_settings.svh ====
// clock division and delay-line geometry macros
// plus the keyboard debounce length
`ifndef EC_SETTINGS_SVH
`define EC_SETTINGS_SVH

// master clock cycles in one bit time
`define EC_CLK_PER_BIT 8

// bit times in one digit slot
`define EC_BITS_PER_SLOT 16

// registers kept in the delay line, entry and stack
`define EC_NUM_REGS 2

// digit columns per register
`define EC_NUM_COLS 16

// total bits in circulation
`define EC_DL_LENGTH (`EC_BITS_PER_SLOT * `EC_NUM_REGS * `EC_NUM_COLS)

// clk cycles a key must be held before it is taken
// the reed switches bounced for several ms, any value works here
`define EC_KEYBOARD_DELAY 100

`endif
